// ==== dnc_link_pkg.sv ====
`default_nettype none

package dnc_link_pkg;

  //////////////////////////////////////////////////
  // Fixed-point format and sizes
  //////////////////////////////////////////////////

  // Q1.15 unsigned words, one = 1 << 15
  localparam int DATA_W = 16;
  localparam int FRAC_W = 15;
  localparam logic [DATA_W-1:0] FX_ONE = 16'd32768;

  // Row and column index, matrix up to 8x8
  localparam int IDX_W = 3;
  localparam int N_MAX = 8;

  // Wishbone word address
  localparam int ADR_W = 8;

  // Control region word offsets
  localparam logic [ADR_W-3:0] REG_CTRL   = 6'd0;
  localparam logic [ADR_W-3:0] REG_STATUS = 6'd1;
  localparam logic [ADR_W-3:0] REG_SIZE   = 6'd2;

  //////////////////////////////////////////////////
  // Bus and address types
  //////////////////////////////////////////////////

  // Top two address bits select the region
  typedef enum logic [1:0] {
    RGN_CTRL = 2'd0,
    RGN_W    = 2'd1,
    RGN_P    = 2'd2,
    RGN_L    = 2'd3
  } region_e;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADR_W-1:0]  adr;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  // Vector view, used for control, w and p
  typedef struct packed {
    region_e          region;
    logic [2:0]       unused;
    logic [IDX_W-1:0] index;
  } vec_addr_t;

  // Matrix view, used for L
  typedef struct packed {
    region_e          region;
    logic [IDX_W-1:0] g;
    logic [IDX_W-1:0] j;
  } mat_addr_t;

  typedef union packed {
    vec_addr_t vec;
    mat_addr_t mat;
  } link_addr_u;

  //////////////////////////////////////////////////
  // Pipeline records
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [IDX_W-1:0] g;
    logic [IDX_W-1:0] j;
  } link_rd_t;

  typedef struct packed {
    logic              valid;
    logic              last;
    logic [IDX_W-1:0]  g;
    logic [IDX_W-1:0]  j;
    logic [DATA_W-1:0] wg;
    logic [DATA_W-1:0] wj;
    logic [DATA_W-1:0] pj;
    logic [DATA_W-1:0] lgj;
  } link_opnd_t;

  typedef struct packed {
    logic              valid;
    logic              last;
    logic [IDX_W-1:0]  g;
    logic [IDX_W-1:0]  j;
    logic [DATA_W-1:0] value;
  } link_res_t;

endpackage

`default_nettype wire

// ==== dnc_link_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module dnc_link_regs (
  input  wire                                CLK,
  input  wire                                RST,
  // Wishbone classic slave
  input  dnc_link_pkg::wb_req_t              wb_req,
  output logic [dnc_link_pkg::DATA_W-1:0]    wb_dat_r,
  output logic                               wb_ack,
  // Run control towards stage 1
  output logic                               start,
  output logic [3:0]                         size_n,
  // Operand read port
  input  dnc_link_pkg::link_rd_t             rd,
  output logic [dnc_link_pkg::DATA_W-1:0]    wg,
  output logic [dnc_link_pkg::DATA_W-1:0]    wj,
  output logic [dnc_link_pkg::DATA_W-1:0]    pj,
  output logic [dnc_link_pkg::DATA_W-1:0]    lgj,
  // Write-back port
  input  dnc_link_pkg::link_res_t            res
);

  import dnc_link_pkg::*;

  //////////////////////////////////////////////////
  // Storage and state
  //////////////////////////////////////////////////

  logic [DATA_W-1:0] w_mem [N_MAX];
  logic [DATA_W-1:0] p_mem [N_MAX];
  logic [DATA_W-1:0] l_mem [N_MAX][N_MAX];

  logic [3:0]        size_q;
  logic              busy;

  // Address seen through both views
  link_addr_u        adr_u;
  logic [ADR_W-3:0]  ctrl_sel;
  logic              vec_ok;

  logic              req_new;
  logic              wr_en;
  logic              start_acc;
  logic [3:0]        size_wr;
  logic [DATA_W-1:0] rd_data;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign adr_u    = wb_req.adr;
  assign ctrl_sel = {adr_u.vec.unused, adr_u.vec.index};
  // Vector words only where the spare bits are zero
  assign vec_ok   = (adr_u.vec.unused == '0);

  // New request, not yet acked
  assign req_new  = wb_req.cyc & wb_req.stb & ~wb_ack;
  // Host writes locked out for the whole run
  assign wr_en    = req_new & wb_req.we & ~busy;

  assign start_acc = wr_en & (adr_u.vec.region == RGN_CTRL) &
                     (ctrl_sel == REG_CTRL) & wb_req.dat[0];

  // SIZE clamp to 1..N_MAX
  always_comb begin
    if (wb_req.dat == '0) begin
      size_wr = 4'd1;
    end else if (wb_req.dat > DATA_W'(N_MAX)) begin
      size_wr = 4'(N_MAX);
    end else begin
      size_wr = wb_req.dat[3:0];
    end
  end

  // Host read mux, unmapped words give zero
  always_comb begin
    rd_data = '0;
    case (adr_u.vec.region)
      RGN_CTRL: begin
        if (ctrl_sel == REG_STATUS) begin
          rd_data = {{(DATA_W-1){1'b0}}, busy};
        end else if (ctrl_sel == REG_SIZE) begin
          rd_data = {{(DATA_W-4){1'b0}}, size_q};
        end
      end
      RGN_W:   if (vec_ok) rd_data = w_mem[adr_u.vec.index];
      RGN_P:   if (vec_ok) rd_data = p_mem[adr_u.vec.index];
      RGN_L:   rd_data = l_mem[adr_u.mat.g][adr_u.mat.j];
      default: rd_data = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Bus cycle, busy and storage updates
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
      start    <= 1'b0;
      busy     <= 1'b0;
      size_q   <= 4'(N_MAX);
      for (int i = 0; i < N_MAX; i++) begin
        w_mem[i] <= '0;
        p_mem[i] <= '0;
        for (int k = 0; k < N_MAX; k++) begin
          l_mem[i][k] <= '0;
        end
      end
    end else begin
      // Single wait state, ack one clock after the request
      wb_ack <= req_new;
      start  <= start_acc;
      if (req_new) begin
        wb_dat_r <= rd_data;
      end

      // Busy from the cycle after start to the last write-back
      if (start) begin
        busy <= 1'b1;
      end else if (res.valid && res.last) begin
        busy <= 1'b0;
      end

      if (wr_en) begin
        case (adr_u.vec.region)
          RGN_CTRL: if (ctrl_sel == REG_SIZE) size_q <= size_wr;
          RGN_W:    if (vec_ok) w_mem[adr_u.vec.index] <= wb_req.dat;
          RGN_P:    if (vec_ok) p_mem[adr_u.vec.index] <= wb_req.dat;
          RGN_L:    l_mem[adr_u.mat.g][adr_u.mat.j] <= wb_req.dat;
          default:  ;
        endcase
      end

      // Pipeline result, in place
      if (res.valid) begin
        l_mem[res.g][res.j] <= res.value;
      end
    end
  end

  //////////////////////////////////////////////////
  // Operand port, combinational
  //////////////////////////////////////////////////

  assign wg     = w_mem[rd.g];
  assign wj     = w_mem[rd.j];
  assign pj     = p_mem[rd.j];
  assign lgj    = l_mem[rd.g][rd.j];

  assign size_n = size_q;

endmodule

`default_nettype wire

// ==== dnc_temporal_link_matrix.sv ====
`timescale 1ns/100ps
`default_nettype none

module dnc_temporal_link_matrix (
  input  wire                              CLK,
  input  wire                              RST,
  input  wire                              start,
  input  wire  [3:0]                       size_n,
  // Operand fetch
  output dnc_link_pkg::link_rd_t           rd,
  input  wire  [dnc_link_pkg::DATA_W-1:0]  wg,
  input  wire  [dnc_link_pkg::DATA_W-1:0]  wj,
  input  wire  [dnc_link_pkg::DATA_W-1:0]  pj,
  input  wire  [dnc_link_pkg::DATA_W-1:0]  lgj,
  // Stage 1 record
  output dnc_link_pkg::link_opnd_t         opnd
);

  import dnc_link_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } state_e;

  state_e            state;
  logic [IDX_W-1:0]  g_cnt;
  logic [IDX_W-1:0]  j_cnt;
  // Size captured at start
  logic [3:0]        n_q;
  logic [IDX_W-1:0]  n_top;
  logic              last_elem;

  logic              valid_q;
  logic              last_q;
  logic [IDX_W-1:0]  g_q;
  logic [IDX_W-1:0]  j_q;
  logic [DATA_W-1:0] wg_q;
  logic [DATA_W-1:0] wj_q;
  logic [DATA_W-1:0] pj_q;
  logic [DATA_W-1:0] lgj_q;

  // Highest index, n is 1..8 so it fits IDX_W
  assign n_top     = IDX_W'(n_q - 4'd1);
  assign last_elem = (g_cnt == n_top) && (j_cnt == n_top);

  //////////////////////////////////////////////////
  // Row-major walk over N x N
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= ST_IDLE;
      g_cnt   <= '0;
      j_cnt   <= '0;
      n_q     <= 4'(N_MAX);
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      // One element per run cycle
      valid_q <= (state == ST_RUN);
      last_q  <= (state == ST_RUN) && last_elem;
      case (state)
        ST_IDLE: begin
          if (start) begin
            n_q   <= size_n;
            g_cnt <= '0;
            j_cnt <= '0;
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (last_elem) begin
            state <= ST_IDLE;
          end else if (j_cnt == n_top) begin
            // Next row
            j_cnt <= '0;
            g_cnt <= g_cnt + 1'b1;
          end else begin
            j_cnt <= j_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Indices straight to the register file
  always_comb begin
    rd.g = g_cnt;
    rd.j = j_cnt;
  end

  // Operand payload, no reset
  always_ff @(posedge CLK) begin
    g_q   <= g_cnt;
    j_q   <= j_cnt;
    wg_q  <= wg;
    wj_q  <= wj;
    pj_q  <= pj;
    lgj_q <= lgj;
  end

  always_comb begin
    opnd.valid = valid_q;
    opnd.last  = last_q;
    opnd.g     = g_q;
    opnd.j     = j_q;
    opnd.wg    = wg_q;
    opnd.wj    = wj_q;
    opnd.pj    = pj_q;
    opnd.lgj   = lgj_q;
  end

endmodule

`default_nettype wire

// ==== dnc_link_update.sv ====
`timescale 1ns/100ps
`default_nettype none

module dnc_link_update (
  input  wire                        CLK,
  input  wire                        RST,
  input  dnc_link_pkg::link_opnd_t   opnd,
  output dnc_link_pkg::link_res_t    res
);

  import dnc_link_pkg::*;

  // Product after dropping FRAC_W bits
  localparam int PROD_W = 2*DATA_W - FRAC_W;

  //////////////////////////////////////////////////
  // Stage 2 logic
  //////////////////////////////////////////////////

  logic [DATA_W:0]     w_sum;
  logic [DATA_W-1:0]   decay;
  logic                diag;
  logic [2*DATA_W-1:0] mul_l;
  logic [2*DATA_W-1:0] mul_w;

  logic                s2_valid;
  logic                s2_last;
  logic [IDX_W-1:0]    s2_g;
  logic [IDX_W-1:0]    s2_j;
  logic [PROD_W-1:0]   s2_prod_l;
  logic [PROD_W-1:0]   s2_prod_w;

  // Stage 3 sum
  logic [PROD_W:0]     sum;
  logic [DATA_W-1:0]   sat;

  // 1 - w[g] - w[j], clamped at zero
  assign w_sum = {1'b0, opnd.wg} + {1'b0, opnd.wj};
  assign decay = (w_sum >= {1'b0, FX_ONE}) ? '0 : FX_ONE - w_sum[DATA_W-1:0];
  assign diag  = (opnd.g == opnd.j);

  // decay * L[g][j] and w[g] * p[j]
  assign mul_l = decay * opnd.lgj;
  assign mul_w = opnd.wg * opnd.pj;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
    end else begin
      s2_valid <= opnd.valid;
      s2_last  <= opnd.last;
    end
  end

  // Decay folded into the truncated product
  always_ff @(posedge CLK) begin
    s2_g <= opnd.g;
    s2_j <= opnd.j;
    if (diag) begin
      // Self links always zero
      s2_prod_l <= '0;
      s2_prod_w <= '0;
    end else begin
      s2_prod_l <= mul_l[2*DATA_W-1:FRAC_W];
      s2_prod_w <= mul_w[2*DATA_W-1:FRAC_W];
    end
  end

  //////////////////////////////////////////////////
  // Stage 3 sum and saturation
  //////////////////////////////////////////////////

  assign sum = {1'b0, s2_prod_l} + {1'b0, s2_prod_w};
  // Saturate at one
  assign sat = (sum > (PROD_W+1)'(FX_ONE)) ? FX_ONE : sum[DATA_W-1:0];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      res <= '0;
    end else begin
      res.valid <= s2_valid;
      res.last  <= s2_last;
      res.g     <= s2_g;
      res.j     <= s2_j;
      res.value <= sat;
    end
  end

endmodule

`default_nettype wire

// ==== dnc_link_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dnc_link_top (
  input  wire                              CLK,
  input  wire                              RST,
  input  dnc_link_pkg::wb_req_t            wb_req,
  output logic [dnc_link_pkg::DATA_W-1:0]  wb_dat_r,
  output logic                             wb_ack
);

  import dnc_link_pkg::*;

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////

  // Run control
  logic              start;
  logic [3:0]        size_n;

  // Operand fetch
  link_rd_t          rd;
  logic [DATA_W-1:0] wg;
  logic [DATA_W-1:0] wj;
  logic [DATA_W-1:0] pj;
  logic [DATA_W-1:0] lgj;

  // Stage records
  link_opnd_t        opnd;
  link_res_t         res;

  // Register file, bus slave and write-back target
  dnc_link_regs dnc_link_regs_inst (
    .CLK      (CLK),
    .RST      (RST),
    .wb_req   (wb_req),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .start    (start),
    .size_n   (size_n),
    .rd       (rd),
    .wg       (wg),
    .wj       (wj),
    .pj       (pj),
    .lgj      (lgj),
    .res      (res)
  );

  // Stage 1 sequencer and operand fetch
  dnc_temporal_link_matrix dnc_temporal_link_matrix_inst (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .size_n (size_n),
    .rd     (rd),
    .wg     (wg),
    .wj     (wj),
    .pj     (pj),
    .lgj    (lgj),
    .opnd   (opnd)
  );

  // Stages 2 and 3
  dnc_link_update dnc_link_update_inst (
    .CLK  (CLK),
    .RST  (RST),
    .opnd (opnd),
    .res  (res)
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic RST
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES   = 10;

  // Free-running 40 ns clock
  initial begin
    CLK = 1'b0;
    forever #(HALF_PERIOD_NS) CLK = ~CLK;
  end

  // Reset for the first cycles, released just after an edge
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    #2;
    RST = 1'b0;
  end

endmodule

`default_nettype wire

// ==== dnc_link_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dnc_link_tb;

  import dnc_link_pkg::*;

  //////////////////////////////////////////////////
  // Limits and run length
  //////////////////////////////////////////////////

  localparam int CLK_PERIOD_NS  = 40;
  localparam int RESET_CYCLES   = 10;
  localparam int ACK_LIMIT      = 16;
  localparam int POLL_LIMIT     = 200;
  // Upper bound on bus accesses over all tests, two cycles each
  localparam int BUS_ACCESS_MAX = 1000;
  localparam int RUN_COUNT      = 5;
  // Twice the worst-case length of all tests
  localparam int WATCHDOG_CYCLES =
    2 * (RESET_CYCLES + 2 * BUS_ACCESS_MAX + RUN_COUNT * (N_MAX * N_MAX + 3));

  localparam logic [ADR_W-1:0] ADR_CTRL   = {2'b00, REG_CTRL};
  localparam logic [ADR_W-1:0] ADR_STATUS = {2'b00, REG_STATUS};
  localparam logic [ADR_W-1:0] ADR_SIZE   = {2'b00, REG_SIZE};

  logic              CLK;
  logic              RST;
  wb_req_t           wb_req;
  logic [DATA_W-1:0] wb_dat_r;
  logic              wb_ack;

  integer            seed;
  int                err_count;
  int                check_count;
  int                err_start;
  logic [DATA_W-1:0] rdata;

  // Host-side model of w, p and L
  logic [DATA_W-1:0] w_m   [N_MAX];
  logic [DATA_W-1:0] p_m   [N_MAX];
  logic [DATA_W-1:0] l_m   [N_MAX][N_MAX];
  logic [DATA_W-1:0] exp_l [N_MAX][N_MAX];
  logic [DATA_W-1:0] rd_l  [N_MAX][N_MAX];

  // Handshake with the readback process
  logic              cmp_req;
  int                cmp_n;
  logic              saw_busy;

  tb_clock_gen tb_clock_gen_inst (
    .CLK (CLK),
    .RST (RST)
  );

  dnc_link_top dnc_link_top_inst (
    .CLK      (CLK),
    .RST      (RST),
    .wb_req   (wb_req),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  //////////////////////////////////////////////////
  // Addresses, random values and the reference
  //////////////////////////////////////////////////

  function automatic logic [ADR_W-1:0] addr_w(input int i);
    return {2'b01, 3'b000, 3'(i)};
  endfunction

  function automatic logic [ADR_W-1:0] addr_p(input int i);
    return {2'b10, 3'b000, 3'(i)};
  endfunction

  function automatic logic [ADR_W-1:0] addr_l(input int g, input int j);
    return {2'b11, 3'(g), 3'(j)};
  endfunction

  // Uniform value in lo..hi
  function automatic logic [DATA_W-1:0] draw(input int lo, input int hi);
    return DATA_W'(lo + ($unsigned($random(seed)) % (hi - lo + 1)));
  endfunction

  // Expected element, Q1.15 with truncated products and saturation at one
  function automatic logic [DATA_W-1:0] link_ref(input logic [DATA_W-1:0] wg,
                                                input logic [DATA_W-1:0] wj,
                                                input logic [DATA_W-1:0] pj,
                                                input logic [DATA_W-1:0] l_old,
                                                input logic diag);
    int unsigned w_sum;
    int unsigned decay;
    int unsigned prod_l;
    int unsigned prod_w;
    int unsigned total;
    if (diag) begin
      return '0;
    end
    w_sum = 32'(wg) + 32'(wj);
    // Decay clamped at zero
    decay = (w_sum >= 32'(FX_ONE)) ? 0 : 32'(FX_ONE) - w_sum;
    prod_l = (decay * 32'(l_old)) >> FRAC_W;
    prod_w = (32'(wg) * 32'(pj)) >> FRAC_W;
    total = prod_l + prod_w;
    if (total > 32'(FX_ONE)) begin
      return FX_ONE;
    end
    return total[DATA_W-1:0];
  endfunction

  task automatic check_val(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                           input string msg);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Wishbone classic master
  //////////////////////////////////////////////////

  // Hold the request until ack, then one idle cycle with stb low
  task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
                           input logic [DATA_W-1:0] dat, output logic [DATA_W-1:0] q);
    int waited;
    waited = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    do begin
      @(posedge CLK);
      #2;
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    if (!wb_ack) begin
      err_count++;
      $display("ERROR: no Wishbone ack within %0d cycles at address %h", ACK_LIMIT, adr);
    end
    q = wb_dat_r;
    wb_req = '0;
    @(posedge CLK);
    #2;
  endtask

  task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] dat);
    logic [DATA_W-1:0] unused_q;
    bus_cycle(1'b1, adr, dat, unused_q);
  endtask

  task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DATA_W-1:0] q);
    bus_cycle(1'b0, adr, '0, q);
  endtask

  //////////////////////////////////////////////////
  // Test steps
  //////////////////////////////////////////////////

  task automatic load_vectors(input int w_lo, input int w_hi, input int p_lo, input int p_hi);
    for (int i = 0; i < N_MAX; i++) begin
      w_m[i] = draw(w_lo, w_hi);
      p_m[i] = draw(p_lo, p_hi);
      wb_write(addr_w(i), w_m[i]);
      wb_write(addr_p(i), p_m[i]);
    end
  endtask

  task automatic load_matrix(input int lo, input int hi);
    for (int g = 0; g < N_MAX; g++) begin
      for (int j = 0; j < N_MAX; j++) begin
        l_m[g][j] = draw(lo, hi);
        wb_write(addr_l(g, j), l_m[g][j]);
      end
    end
  endtask

  // Expected matrix from pre-run values, outside N unchanged
  task automatic predict_run(input int n);
    for (int g = 0; g < N_MAX; g++) begin
      for (int j = 0; j < N_MAX; j++) begin
        if (g < n && j < n) begin
          exp_l[g][j] = link_ref(w_m[g], w_m[j], p_m[j], l_m[g][j], g == j);
        end else begin
          exp_l[g][j] = l_m[g][j];
        end
      end
    end
    cmp_n = n;
  endtask

  // Poll STATUS until busy drops
  task automatic wait_idle();
    logic [DATA_W-1:0] st;
    int polls;
    polls = 0;
    saw_busy = 1'b0;
    st = 16'h0001;
    while (st[0] && polls < POLL_LIMIT) begin
      wb_read(ADR_STATUS, st);
      if (st[0]) begin
        saw_busy = 1'b1;
      end
      polls++;
    end
    if (st[0]) begin
      err_count++;
      $display("ERROR: busy still set after %0d STATUS polls", POLL_LIMIT);
    end
  endtask

  task automatic compare_all();
    cmp_req = 1'b1;
    wait (cmp_req === 1'b0);
  endtask

  task automatic run_and_check(input int n);
    predict_run(n);
    wb_write(ADR_CTRL, 16'h0001);
    wait_idle();
    // Run must have raised busy before it dropped
    check_val(DATA_W'(saw_busy), 16'h0001, "busy seen after start");
    compare_all();
  endtask

  // Readback of the whole L after a run
  initial begin : readback_compare
    logic [DATA_W-1:0] got;
    forever begin
      wait (cmp_req === 1'b1);
      for (int g = 0; g < N_MAX; g++) begin
        for (int j = 0; j < N_MAX; j++) begin
          wb_read(addr_l(g, j), got);
          rd_l[g][j] = got;
          check_val(got, exp_l[g][j], $sformatf("L[%0d][%0d] after run", g, j));
          if (g == j && g < cmp_n) begin
            check_val(got, '0, $sformatf("diagonal L[%0d][%0d]", g, j));
          end
          l_m[g][j] = exp_l[g][j];
        end
      end
      cmp_req = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    wb_req      = '0;
    cmp_req     = 1'b0;
    cmp_n       = N_MAX;
    saw_busy    = 1'b0;
    err_count   = 0;
    check_count = 0;
    seed        = 32'h6f60;
    for (int g = 0; g < N_MAX; g++) begin
      w_m[g] = '0;
      p_m[g] = '0;
      for (int j = 0; j < N_MAX; j++) begin
        l_m[g][j] = '0;
      end
    end
    wait (RST === 1'b0);
    @(posedge CLK);
    #2;

    // Register access, SIZE clamp and unmapped words
    err_start = err_count;
    wb_read(ADR_SIZE, rdata);
    check_val(rdata, 16'd8, "SIZE after reset");
    for (int i = 0; i < N_MAX; i++) begin
      w_m[i] = draw(0, 65535);
      p_m[i] = draw(0, 65535);
      l_m[i][N_MAX-1-i] = draw(0, 65535);
      wb_write(addr_w(i), w_m[i]);
      wb_write(addr_p(i), p_m[i]);
      wb_write(addr_l(i, N_MAX-1-i), l_m[i][N_MAX-1-i]);
    end
    for (int i = 0; i < N_MAX; i++) begin
      wb_read(addr_w(i), rdata);
      check_val(rdata, w_m[i], $sformatf("w[%0d] readback", i));
      wb_read(addr_p(i), rdata);
      check_val(rdata, p_m[i], $sformatf("p[%0d] readback", i));
      wb_read(addr_l(i, N_MAX-1-i), rdata);
      check_val(rdata, l_m[i][N_MAX-1-i], $sformatf("L[%0d][%0d] readback", i, N_MAX-1-i));
    end
    wb_write(ADR_SIZE, 16'd0);
    wb_read(ADR_SIZE, rdata);
    check_val(rdata, 16'd1, "SIZE clamp of 0");
    wb_write(ADR_SIZE, 16'd5);
    wb_read(ADR_SIZE, rdata);
    check_val(rdata, 16'd5, "SIZE of 5");
    wb_write(ADR_SIZE, 16'hffff);
    wb_read(ADR_SIZE, rdata);
    check_val(rdata, 16'd8, "SIZE clamp of ffff");
    wb_write(ADR_SIZE, 16'd8);
    // w region with spare address bits set
    wb_write(8'h48, 16'hbeef);
    wb_read(8'h48, rdata);
    check_val(rdata, '0, "unmapped 48");
    wb_read(addr_w(0), rdata);
    check_val(rdata, w_m[0], "w[0] after unmapped write");
    wb_read(8'h03, rdata);
    check_val(rdata, '0, "unmapped 03");
    wb_read(8'h88, rdata);
    check_val(rdata, '0, "unmapped 88");
    wb_read(ADR_STATUS, rdata);
    check_val(rdata, '0, "STATUS idle");
    $display("test 1 register access: %0d errors", err_count - err_start);

    // Full 8x8, pair sums at most one
    err_start = err_count;
    load_vectors(0, 16384, 0, 32768);
    load_matrix(0, 32768);
    run_and_check(8);
    $display("test 2 full 8x8 update: %0d errors", err_count - err_start);

    // 3x3 corner only
    err_start = err_count;
    wb_write(ADR_SIZE, 16'd3);
    load_vectors(0, 16384, 0, 32768);
    run_and_check(3);
    wb_write(ADR_SIZE, 16'd8);
    $display("test 3 reduced size: %0d errors", err_count - err_start);

    // Decay clamped to zero, so old L drops out
    err_start = err_count;
    load_vectors(16384, 32768, 0, 16384);
    run_and_check(8);
    for (int g = 0; g < N_MAX; g++) begin
      for (int j = 0; j < N_MAX; j++) begin
        if (g != j) begin
          check_val(rd_l[g][j], link_ref(w_m[g], w_m[j], p_m[j], '0, 1'b0),
                    $sformatf("clamped decay L[%0d][%0d]", g, j));
        end
      end
    end
    // Product above one, sum saturates
    load_vectors(24576, 32768, 49152, 65535);
    run_and_check(8);
    for (int g = 0; g < N_MAX; g++) begin
      for (int j = 0; j < N_MAX; j++) begin
        if (g != j) begin
          check_val(rd_l[g][j], FX_ONE, $sformatf("saturated L[%0d][%0d]", g, j));
        end
      end
    end
    $display("test 4 saturation and clamping: %0d errors", err_count - err_start);

    // Host writes during the run are dropped
    err_start = err_count;
    load_vectors(0, 16384, 0, 32768);
    predict_run(8);
    wb_write(ADR_CTRL, 16'h0001);
    wb_write(addr_l(1, 2), 16'h1234);
    wb_write(addr_w(0), 16'h7777);
    wb_write(ADR_SIZE, 16'd3);
    wb_read(ADR_STATUS, rdata);
    check_val(rdata, 16'h0001, "STATUS busy during run");
    wait_idle();
    compare_all();
    wb_read(addr_w(0), rdata);
    check_val(rdata, w_m[0], "w[0] after write while busy");
    wb_read(ADR_SIZE, rdata);
    check_val(rdata, 16'd8, "SIZE after write while busy");
    $display("test 5 busy protection: %0d errors", err_count - err_start);

    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("ERROR: watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
dnc_link_pkg.sv
dnc_link_regs.sv
dnc_temporal_link_matrix.sv
dnc_link_update.sv
dnc_link_top.sv
tb_clock_gen.sv
dnc_link_tb.sv
